//--- include/fdc_params.svh
/* FDC parameters
   Widths, counts and fixed status codes shared by the controller */
`ifndef FDC_PARAMS_SVH
`define FDC_PARAMS_SVH

`define FDC_DATA_W      8       // Byte width on both buses
`define FDC_NUM_DRIVES  4       // Drive units, one track each
`define FDC_PCNT_W      4       // Parameter and result counters
`define FDC_PTR_W       3       // Pattern step pointer
`define FDC_SUP_ADDR_W  4       // Support register address

// Fixed sector size code at support address 0
`define FDC_SZ_CODE     8'd2

// S0 error field values, bits 7:6
`define FDC_INVAL_S0    2'b10   // Invalid command
`define FDC_NOTRDY_S0   2'b11   // Drive not ready

`endif

//--- hdl/fdc_pkg.sv
/* FDC package
   State, opcode and register index enums plus the buses between blocks */
`include "fdc_params.svh"

package fdc_pkg;

	// Command phase states
	typedef enum logic [2:0]
	{
		IDLE,
		PARAM,
		PRERESULT,      // One cycle, status bytes built here
		RESULT
	} fdc_state_e;

	// Commands kept by this model
	typedef enum logic [4:0]
	{
		SPECIFY     = 5'h03,
		SENSE_DRIVE = 5'h04,
		RECALIBRATE = 5'h07,
		SENSE_INT   = 5'h08,
		SEEK        = 5'h0F
	} fdc_opcode_e;

	// Register index, shared by the patterns and the support port
	typedef enum logic [3:0]
	{
		SZ       = 4'd0,    // Fixed size code
		SUP_STAT = 4'd1,    // Last opcode
		HU       = 4'd2,
		TR       = 4'd4,
		S0       = 4'd8,
		S3       = 4'd11,
		TP       = 4'd13,
		HRES     = 4'd14,   // Written by the support CPU only
		NOP      = 4'd15
	} fdc_reg_e;

	typedef struct packed
	{
		logic       valid;
		logic [2:0] param_count;
		logic [2:0] result_count;
		logic [1:0] param_ptn;
		logic [1:0] result_ptn;
	} cmd_attr_t;

	typedef struct packed
	{
		logic                   en;
		fdc_reg_e               idx;
		logic [`FDC_DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed
	{
		logic [4:0] opcode;
		logic       invalid;
		logic       finish;     // Pulse in PRERESULT
	} cmd_ctx_t;

	typedef struct packed
	{
		logic [`FDC_SUP_ADDR_W-1:0] addr;
		logic [`FDC_DATA_W-1:0]     data;
		logic                       wr;
	} sup_bus_t;

endpackage

//--- hdl/fdc_cmd_table.sv
/* FDC command table
   Opcode attributes and the parameter and result register patterns */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_cmd_table
	import fdc_pkg::*;
(
	input  logic [4:0]            opcode_i,
	input  logic [1:0]            param_ptn_i,
	input  logic [`FDC_PTR_W-1:0] param_step_i,
	input  logic [1:0]            result_ptn_i,
	input  logic [`FDC_PTR_W-1:0] result_step_i,
	output cmd_attr_t             attr_o,
	output fdc_reg_e              param_idx_o,
	output fdc_reg_e              result_idx_o
);

	// Parameter patterns
	localparam logic [1:0] PPTN_NONE = 2'd0;   // Bytes discarded
	localparam logic [1:0] PPTN_UNIT = 2'd1;   // HU
	localparam logic [1:0] PPTN_SEEK = 2'd2;   // HU, TP
	// Result patterns
	localparam logic [1:0] RPTN_S0   = 2'd0;   // S0
	localparam logic [1:0] RPTN_S3   = 2'd1;   // S3
	localparam logic [1:0] RPTN_INT  = 2'd2;   // S0, TP

	function automatic fdc_reg_e param_pattern(input logic [1:0] ptn,
		input logic [`FDC_PTR_W-1:0] step);
		fdc_reg_e idx;
		idx = NOP;                                  // Past the end
		case (ptn)
			PPTN_UNIT: if (step == 0) idx = HU;
			PPTN_SEEK:
			begin
				if (step == 0)
					idx = HU;
				else if (step == 1)
					idx = TP;
			end
			default: idx = NOP;                     // Specify bytes land nowhere
		endcase
		return idx;
	endfunction

	function automatic fdc_reg_e result_pattern(input logic [1:0] ptn,
		input logic [`FDC_PTR_W-1:0] step);
		fdc_reg_e idx;
		idx = NOP;
		if (step == 0)
			idx = (ptn == RPTN_S3) ? S3 : S0;       // First byte
		else if (step == 1 && ptn == RPTN_INT)
			idx = TP;                               // Present cylinder
		return idx;
	endfunction

	always_comb
	begin
		case (opcode_i)
			SPECIFY:     attr_o = '{1'b1, 3'd2, 3'd0, PPTN_NONE, RPTN_S0};
			SENSE_DRIVE: attr_o = '{1'b1, 3'd1, 3'd1, PPTN_UNIT, RPTN_S3};
			RECALIBRATE: attr_o = '{1'b1, 3'd1, 3'd0, PPTN_UNIT, RPTN_S0};
			SENSE_INT:   attr_o = '{1'b1, 3'd0, 3'd2, PPTN_NONE, RPTN_INT}; // No params
			SEEK:        attr_o = '{1'b1, 3'd2, 3'd0, PPTN_SEEK, RPTN_S0};
			default:     attr_o = '{1'b0, 3'd0, 3'd1, PPTN_NONE, RPTN_S0}; // S0 only
		endcase
	end

	assign param_idx_o  = param_pattern(param_ptn_i, param_step_i);
	assign result_idx_o = result_pattern(result_ptn_i, result_step_i);

endmodule

//--- hdl/fdc_sequencer.sv
/* FDC sequencer
   Command, parameter and result phases on the CPU bus, with main status */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_sequencer
	import fdc_pkg::*;
(
	input  logic                   sup_clk_i,
	input  logic                   reset_i,
	input  logic [`FDC_DATA_W-1:0] cpu_data_i,
	input  logic                   regsel_i,      // 0 status, 1 data
	input  logic                   rd_i,
	input  logic                   wr_i,
	output logic [`FDC_DATA_W-1:0] cpu_data_o,
	input  logic [3:0]             drive_active_i,
	input  logic [`FDC_DATA_W-1:0] result_data_i,
	output logic [4:0]             opcode_o,
	output logic [1:0]             param_ptn_o,
	output logic [1:0]             result_ptn_o,
	output logic [`FDC_PTR_W-1:0]  param_step_o,
	output logic [`FDC_PTR_W-1:0]  result_step_o,
	input  cmd_attr_t              attr_i,
	input  fdc_reg_e               param_idx_i,
	input  fdc_reg_e               result_idx_i,
	output reg_wr_t                reg_wr_o,
	output cmd_ctx_t               ctx_o
);

	fdc_state_e             state_q;
	logic                   rd_q, wr_q;           // Previous strobe levels
	logic                   rd_rise, wr_rise;
	logic [4:0]             opcode_q;
	cmd_attr_t              attr_q;
	logic [`FDC_PCNT_W-1:0] prm_cnt_q, res_cnt_q;
	logic [`FDC_PTR_W-1:0]  prm_step_q, res_step_q;
	logic [`FDC_DATA_W-1:0] res_q;                // Result register
	logic [`FDC_DATA_W-1:0] status_main;

	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end
		else
		begin
			rd_q <= rd_i;
			wr_q <= wr_i;
		end
	end

	// Only data register accesses step the FSM
	assign rd_rise = rd_i & ~rd_q & regsel_i;
	assign wr_rise = wr_i & ~wr_q & regsel_i;

	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			state_q    <= IDLE;
			opcode_q   <= '0;
			attr_q     <= '0;
			prm_cnt_q  <= '0;
			res_cnt_q  <= '0;
			prm_step_q <= '0;
			res_step_q <= '0;
			res_q      <= 8'hFF;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (wr_rise)
					begin
						opcode_q   <= cpu_data_i[4:0];    // Command byte
						attr_q     <= attr_i;             // Live lookup of that byte
						prm_cnt_q  <= `FDC_PCNT_W'(attr_i.param_count);
						prm_step_q <= '0;
						res_step_q <= '0;
						// Sense interrupt and bad opcodes skip PARAM
						if (attr_i.valid && attr_i.param_count != 3'd0)
							state_q <= PARAM;
						else
							state_q <= PRERESULT;
					end
				end
				PARAM:
				begin
					if (wr_rise)
					begin
						if (prm_cnt_q == `FDC_PCNT_W'(1))
							state_q <= PRERESULT;         // Last parameter
						else
						begin
							prm_cnt_q  <= prm_cnt_q - 1'b1;
							prm_step_q <= prm_step_q + 1'b1;
						end
					end
				end
				PRERESULT:
				begin
					res_cnt_q <= `FDC_PCNT_W'(attr_q.result_count);
					state_q   <= (attr_q.result_count != 3'd0) ? RESULT : IDLE;
				end
				RESULT:
				begin
					if (rd_rise)
					begin
						if (res_cnt_q != '0)
						begin
							res_q      <= result_data_i;  // Byte for current step
							res_cnt_q  <= res_cnt_q - 1'b1;
							res_step_q <= res_step_q + 1'b1;
						end
					end
					else if (res_cnt_q == '0)
						state_q <= IDLE;                  // All bytes handed out
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Live data byte while idle, latched command afterwards
	assign opcode_o      = (state_q == IDLE) ? cpu_data_i[4:0] : opcode_q;
	assign param_ptn_o   = attr_q.param_ptn;
	assign result_ptn_o  = attr_q.result_ptn;
	assign param_step_o  = prm_step_q;
	assign result_step_o = res_step_q;

	always_comb
	begin
		reg_wr_o.en   = (state_q == PARAM) && wr_rise;  // Lands at the detect edge
		reg_wr_o.idx  = param_idx_i;
		reg_wr_o.data = cpu_data_i;
	end

	always_comb
	begin
		ctx_o.opcode  = opcode_q;
		ctx_o.invalid = ~attr_q.valid;
		ctx_o.finish  = (state_q == PRERESULT);
	end

	assign status_main = {
		state_q != PRERESULT,       // RQM
		state_q == RESULT,          // DIO toward the CPU
		1'b0,                       // No execution phase here
		state_q != IDLE,            // Controller busy
		drive_active_i
	};

	always_comb
	begin
		if (!regsel_i)
			cpu_data_o = status_main;
		else if (state_q == RESULT)
			cpu_data_o = res_q;
		else
			cpu_data_o = 8'hFF;     // Nothing to read
	end

	a_state_legal: assert property (@(posedge sup_clk_i) disable iff (reset_i)
		state_q inside {IDLE, PARAM, PRERESULT, RESULT});

endmodule

//--- hdl/fdc_reg_file.sv
/* FDC register file
   Command registers, per-drive track state, status bytes and support port */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_reg_file
	import fdc_pkg::*;
(
	input  logic                   sup_clk_i,
	input  logic                   reset_i,
	input  reg_wr_t                reg_wr_i,
	input  cmd_ctx_t               ctx_i,
	input  fdc_reg_e               result_idx_i,
	output logic [`FDC_DATA_W-1:0] result_data_o,
	output logic [3:0]             drive_active_o,
	input  sup_bus_t               sup_bus_i,
	output logic [`FDC_DATA_W-1:0] sup_data_o
);

	logic [`FDC_DATA_W-1:0]    hu_q, tp_q, tr_q, s0_q, s3_q, hres_q;
	logic [`FDC_DATA_W-1:0]    track_q [`FDC_NUM_DRIVES];
	logic [`FDC_NUM_DRIVES-1:0] drive_active_q;
	logic                      seek_end_q;
	logic                      int_pend_q;        // Sense interrupt still reading out
	logic                      is_seek, is_recal, is_int;
	logic                      track0;
	logic [1:0]                unit;
	logic [`FDC_DATA_W-1:0]    new_track;
	logic [1:0]                err;

	assign unit      = hu_q[1:0];
	assign is_seek   = ~ctx_i.invalid && (ctx_i.opcode == SEEK);
	assign is_recal  = ~ctx_i.invalid && (ctx_i.opcode == RECALIBRATE);
	assign is_int    = ~ctx_i.invalid && (ctx_i.opcode == SENSE_INT);
	assign new_track = is_seek ? tp_q : '0;        // Recalibrate heads to 0
	assign track0    = (track_q[unit] == '0);

	always_comb
	begin
		if (ctx_i.invalid)
			err = `FDC_INVAL_S0;
		else if (hres_q[0])
			err = `FDC_NOTRDY_S0;                 // Support CPU says not ready
		else
			err = 2'b00;
	end

	// Parameter bytes and status composition
	always_ff @(posedge sup_clk_i)
	begin
		if (reg_wr_i.en)
		begin
			case (reg_wr_i.idx)
				HU:      hu_q <= reg_wr_i.data;
				TP:      tp_q <= reg_wr_i.data;
				default: ;                        // NOP steps drop the byte
			endcase
		end
		if (ctx_i.finish)
		begin
			if (is_seek || is_recal)
				tr_q <= new_track;                // TR follows the head
			// Seek end bit reads as zero whenever the flag is clear
			s0_q <= {err, seek_end_q, hres_q[1], hres_q[0], hu_q[2:0]};
			s3_q <= {1'b0, hres_q[3], 1'b1, track0, 1'b0, hu_q[2:0]};
		end
	end

	// Drive state
	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < `FDC_NUM_DRIVES; i++)
				track_q[i] <= '0;
			drive_active_q <= '0;
			seek_end_q     <= 1'b0;
			int_pend_q     <= 1'b0;
		end
		else if (ctx_i.finish)
		begin
			if (is_seek || is_recal)
			begin
				track_q[unit]        <= new_track;
				drive_active_q[unit] <= 1'b1;     // Drive busy until sensed
				seek_end_q           <= 1'b1;
			end
			else
				seek_end_q <= 1'b0;               // Reported once in S0
			if (is_int)
				int_pend_q <= 1'b1;
		end
		else if (int_pend_q && result_idx_i == NOP)
		begin
			// Busy bits drop once the interrupt result pattern is exhausted
			drive_active_q <= '0;
			int_pend_q     <= 1'b0;
		end
	end

	// Host result byte from the support CPU
	always_ff @(posedge sup_clk_i)
	begin
		if (reset_i)
			hres_q <= '0;
		else if (sup_bus_i.wr && sup_bus_i.addr == HRES)
			hres_q <= sup_bus_i.data;
	end

	function automatic logic [`FDC_DATA_W-1:0] reg_read(input fdc_reg_e idx);
		case (idx)
			SZ:       return `FDC_SZ_CODE;
			SUP_STAT: return `FDC_DATA_W'(ctx_i.opcode);
			HU:       return hu_q;
			TR:       return tr_q;
			S0:       return s0_q;
			S3:       return s3_q;
			TP:       return tp_q;
			HRES:     return hres_q;
			default:  return 8'hFF;               // Unmapped
		endcase
	endfunction

	always_comb
	begin
		result_data_o = reg_read(result_idx_i);
		sup_data_o    = reg_read(fdc_reg_e'(sup_bus_i.addr));
	end

	assign drive_active_o = drive_active_q;

	// HRES belongs to the support side, patterns never point at it
	a_no_hres_param: assert property (@(posedge sup_clk_i) disable iff (reset_i)
		reg_wr_i.en |-> reg_wr_i.idx != HRES);

endmodule

//--- hdl/fdc_top.sv
/* FDC top
   Sequencer, command table and register file on one clock */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_top
	import fdc_pkg::*;
(
	input  logic                   sup_clk_i,
	input  logic                   reset_i,
	// CPU bus
	input  logic [`FDC_DATA_W-1:0] cpu_data_i,
	output logic [`FDC_DATA_W-1:0] cpu_data_o,
	input  logic                   regsel_i,
	input  logic                   rd_i,
	input  logic                   wr_i,
	// Support bus
	input  sup_bus_t               sup_bus_i,
	output logic [`FDC_DATA_W-1:0] sup_data_o
);

	logic [4:0]             opcode;
	logic [1:0]             param_ptn, result_ptn;
	logic [`FDC_PTR_W-1:0]  param_step, result_step;
	cmd_attr_t              attr;
	fdc_reg_e               param_idx, result_idx;
	reg_wr_t                reg_wr;
	cmd_ctx_t               ctx;
	logic [`FDC_DATA_W-1:0] result_data;
	logic [3:0]             drive_active;

	fdc_sequencer u_seq (
		.sup_clk_i      (sup_clk_i),
		.reset_i        (reset_i),
		.cpu_data_i     (cpu_data_i),
		.regsel_i       (regsel_i),
		.rd_i           (rd_i),
		.wr_i           (wr_i),
		.cpu_data_o     (cpu_data_o),
		.drive_active_i (drive_active),
		.result_data_i  (result_data),
		.opcode_o       (opcode),
		.param_ptn_o    (param_ptn),
		.result_ptn_o   (result_ptn),
		.param_step_o   (param_step),
		.result_step_o  (result_step),
		.attr_i         (attr),
		.param_idx_i    (param_idx),
		.result_idx_i   (result_idx),
		.reg_wr_o       (reg_wr),
		.ctx_o          (ctx)
	);

	fdc_cmd_table u_table (
		.opcode_i      (opcode),
		.param_ptn_i   (param_ptn),
		.param_step_i  (param_step),
		.result_ptn_i  (result_ptn),
		.result_step_i (result_step),
		.attr_o        (attr),
		.param_idx_o   (param_idx),
		.result_idx_o  (result_idx)
	);

	fdc_reg_file u_regs (
		.sup_clk_i      (sup_clk_i),
		.reset_i        (reset_i),
		.reg_wr_i       (reg_wr),
		.ctx_i          (ctx),
		.result_idx_i   (result_idx),
		.result_data_o  (result_data),
		.drive_active_o (drive_active),
		.sup_bus_i      (sup_bus_i),
		.sup_data_o     (sup_data_o)
	);

endmodule

//--- test/fdc_checker.sv
/* FDC checker
   Samples the DUT bus outputs, compares them with expected bytes, reports each test */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_checker #(
	parameter int NAME_W = 8*24
) (
	input  logic                   sup_clk_i,
	input  logic                   reset_i,
	input  logic                   chk_en_i,      // Compare this cycle
	input  logic                   chk_sup_i,     // 1 support port, 0 CPU port
	input  logic [`FDC_DATA_W-1:0] exp_i,
	input  logic                   test_end_i,    // Close the current test
	input  logic [NAME_W-1:0]      name_i,
	input  logic [`FDC_DATA_W-1:0] cpu_data_i,
	input  logic [`FDC_DATA_W-1:0] sup_data_i,
	output logic [15:0]            tests_o,
	output logic [15:0]            checks_o,
	output logic [15:0]            errors_o
);

	logic [`FDC_DATA_W-1:0] actual;
	logic [15:0]            test_chk;    // Compares in the open test
	logic [15:0]            test_err;

	assign actual = chk_sup_i ? sup_data_i : cpu_data_i;

	// Sampled at the edge, before the DUT registers move
	always @(posedge sup_clk_i)
	begin
		if (reset_i)
		begin
			tests_o  <= '0;
			checks_o <= '0;
			errors_o <= '0;
			test_chk <= '0;
			test_err <= '0;
		end
		else
		begin
			if (chk_en_i)
			begin
				checks_o <= checks_o + 1'b1;
				test_chk <= test_chk + 1'b1;
				if (actual !== exp_i)
				begin
					$display("error: test %0s, expected %02h, actual %02h",
						name_i, exp_i, actual);
					errors_o <= errors_o + 1'b1;
					test_err <= test_err + 1'b1;
				end
			end
			if (test_end_i)
			begin
				if (test_err == 0)
					$display("test %0s: ok, %0d checks", name_i, test_chk);
				else
					$display("test %0s: %0d of %0d checks wrong", name_i, test_err, test_chk);
				tests_o  <= tests_o + 1'b1;
				test_chk <= '0;
				test_err <= '0;
			end
		end
	end

endmodule

//--- test/fdc_tb.sv
/* FDC testbench
   Replays the stimulus file on the CPU and support buses of the controller */
`timescale 1ns/1ns
`include "fdc_params.svh"

module fdc_tb
	import fdc_pkg::*;
();

	localparam int NAME_W  = 8*24;         // Up to 24 characters per test name
	localparam int MAX_OPS = 256;

	logic                   sup_clk;
	logic                   reset;
	logic [`FDC_DATA_W-1:0] cpu_data_in;
	logic [`FDC_DATA_W-1:0] cpu_data_out;
	logic                   regsel;
	logic                   rd;
	logic                   wr;
	sup_bus_t               sup_bus;
	logic [`FDC_DATA_W-1:0] sup_data;

	logic                   chk_en;
	logic                   chk_sup;
	logic [`FDC_DATA_W-1:0] chk_exp;
	logic                   test_end;
	logic [NAME_W-1:0]      test_name;
	logic [15:0]            tests, checks, errors;

	// Stimulus table, one entry per record of the file
	logic [7:0]             op_mem [MAX_OPS];
	logic [7:0]             arg_a [MAX_OPS];
	logic [7:0]             arg_b [MAX_OPS];
	logic [NAME_W-1:0]      name_mem [MAX_OPS];
	int                     n_ops;
	int                     cycle_limit = 0;
	int                     cycles = 0;
	int                     gap;

	fdc_top dut_i (
		.sup_clk_i  (sup_clk),
		.reset_i    (reset),
		.cpu_data_i (cpu_data_in),
		.cpu_data_o (cpu_data_out),
		.regsel_i   (regsel),
		.rd_i       (rd),
		.wr_i       (wr),
		.sup_bus_i  (sup_bus),
		.sup_data_o (sup_data)
	);

	fdc_checker #(.NAME_W(NAME_W)) u_checker (
		.sup_clk_i  (sup_clk),
		.reset_i    (reset),
		.chk_en_i   (chk_en),
		.chk_sup_i  (chk_sup),
		.exp_i      (chk_exp),
		.test_end_i (test_end),
		.name_i     (test_name),
		.cpu_data_i (cpu_data_out),
		.sup_data_i (sup_data),
		.tests_o    (tests),
		.checks_o   (checks),
		.errors_o   (errors)
	);

	always #5 sup_clk = ~sup_clk;          // 10 ns period

	// Read the whole file up front so the run length is known
	task automatic load_stim();
		int          fd;
		int          code;
		int          c;
		logic [7:0]  op;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [NAME_W-1:0] nm;
		n_ops = 0;
		fd = $fopen("test/fdc_stim.txt", "r");
		if (fd == 0)
			n_ops = -1;
		else
		begin
			code = $fscanf(fd, " %c", op);
			while (code == 1 && n_ops >= 0)
			begin
				a  = '0;
				b  = '0;
				nm = '0;
				case (op)
					"#":
					begin
						c = $fgetc(fd);             // Comment runs to end of line
						while (c != "\n" && c != -1)
							c = $fgetc(fd);
					end
					"T": code = $fscanf(fd, " %s", nm);
					"W", "R", "S": code = $fscanf(fd, " %h", a);
					"U", "V": code = $fscanf(fd, " %h %h", a, b);
					default: n_ops = -1;           // Unknown record
				endcase
				if (op != "#" && n_ops >= 0 && n_ops < MAX_OPS)
				begin
					op_mem[n_ops]   = op;
					arg_a[n_ops]    = a;
					arg_b[n_ops]    = b;
					name_mem[n_ops] = nm;
					n_ops++;
				end
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end
	endtask

	// Strobe high two cycles, low two cycles
	task automatic cpu_write(input logic [7:0] data);
		regsel      = 1'b1;
		cpu_data_in = data;
		wr          = 1'b1;
		repeat (2) @(posedge sup_clk);
		#1;
		wr = 1'b0;
		repeat (2) @(posedge sup_clk);
		#1;
	endtask

	task automatic cpu_read(input logic sel, input logic [7:0] expected);
		regsel = sel;
		rd     = 1'b1;
		@(posedge sup_clk);                  // Edge detected, result byte loads
		#1;
		chk_sup = 1'b0;
		chk_exp = expected;
		chk_en  = 1'b1;
		@(posedge sup_clk);                  // Checker samples, end of high period
		#1;
		chk_en = 1'b0;
		rd     = 1'b0;
		repeat (2) @(posedge sup_clk);
		#1;
	endtask

	task automatic sup_write(input logic [3:0] addr, input logic [7:0] data);
		sup_bus.addr = addr;
		sup_bus.data = data;
		sup_bus.wr   = 1'b1;
		@(posedge sup_clk);
		#1;
		sup_bus.wr = 1'b0;
	endtask

	// Support read data is combinational from the address
	task automatic sup_read(input logic [3:0] addr, input logic [7:0] expected);
		sup_bus.addr = addr;
		sup_bus.wr   = 1'b0;
		chk_sup      = 1'b1;
		chk_exp      = expected;
		chk_en       = 1'b1;
		@(posedge sup_clk);
		#1;
		chk_en = 1'b0;
	endtask

	task automatic end_test();
		test_end = 1'b1;
		@(posedge sup_clk);
		#1;
		test_end = 1'b0;
	endtask

	task automatic idle_gap();
		gap = $urandom % 4;                  // 0 to 3 idle cycles
		repeat (gap)
		begin
			@(posedge sup_clk);
			#1;
		end
	endtask

	task automatic run_ops();
		int   i;
		logic test_open;
		test_open = 1'b0;
		for (i = 0; i < n_ops; i++)
		begin
			case (op_mem[i])
				"T":
				begin
					if (test_open)
						end_test();
					test_name = name_mem[i];
					test_open = 1'b1;
				end
				"W": cpu_write(arg_a[i]);
				"R": cpu_read(1'b1, arg_a[i]);     // Data register
				"S": cpu_read(1'b0, arg_a[i]);     // Main status
				"U": sup_write(arg_a[i][3:0], arg_b[i]);
				"V": sup_read(arg_a[i][3:0], arg_b[i]);
				default: ;
			endcase
			if (op_mem[i] != "T")
				idle_gap();
		end
		if (test_open)
			end_test();
	endtask

	// Run limit from the stimulus length
	always @(posedge sup_clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("timeout: the run was still going after %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	initial
	begin
		sup_clk     = 1'b0;
		reset       = 1'b1;
		cpu_data_in = '0;
		regsel      = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		sup_bus     = '0;
		chk_en      = 1'b0;
		chk_sup     = 1'b0;
		chk_exp     = '0;
		test_end    = 1'b0;
		test_name   = '0;
		gap = $urandom(64);                  // Seed once
		load_stim();
		if (n_ops <= 0)
		begin
			$display("stimulus file test/fdc_stim.txt is missing, empty or malformed");
			$display("Done: errors found");
			$finish;
		end
		else
		begin
			cycle_limit = 20 * n_ops + 50;
			repeat (5) @(posedge sup_clk);
			#1;
			reset = 1'b0;
			run_ops();
			@(posedge sup_clk);
			#1;
			$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0 && checks != 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

//--- test/fdc_stim.txt
# Records: T name | W data | R expected | S expected | U addr data | V addr expected
# W CPU data write, R CPU data read, S status read, U support write, V support read, hex
T reset
S 80
R FF
T seek_sense
W 0F
S 90
W 01
S 90
W 05
S 82
W 08
S D2
R 21
S D2
R 05
S 80
T sense_int_again
W 08
R 01
R 05
S 80
T recal_drive_status
W 07
W 01
S 82
W 04
W 01
R 31
U E 08
W 04
W 01
R 71
T invalid_opcode
W 06
S D2
R 81
S 82
T support_reads
V 0 02
V 1 06
V 2 01
V 4 00
V E 08
V F FF

//--- vlog.f
+incdir+include
hdl/fdc_pkg.sv
hdl/fdc_cmd_table.sv
hdl/fdc_sequencer.sv
hdl/fdc_reg_file.sv
hdl/fdc_top.sv
test/fdc_checker.sv
test/fdc_tb.sv
